// File: rtl/fadd_pkg.sv
//====================
// shared constants and types of the binary32 adder
// referenced by scoped name from every design file
//====================
package fadd_pkg;

    localparam int EXP_W     = 8;   // biased exponent
    localparam int FRAC_W    = 23;  // stored fraction
    localparam int GRS_W     = 3;   // guard, round, sticky
    localparam int MANT_W    = FRAC_W + 1 + GRS_W;  // hidden bit + fraction + grs
    localparam int EXP_MAX   = 254; // largest finite biased exponent
    localparam int MAX_SHIFT = 27;  // whole significand lands in sticky

    typedef enum logic [1:0] {
        RND_ZERO         = 2'd0,
        RND_NEAREST_EVEN = 2'd1,
        RND_POS_INF      = 2'd2,
        RND_NEG_INF      = 2'd3
    } round_e;

    typedef enum logic [2:0] {
        ERR_NONE          = 3'd0,
        ERR_INVALID_INPUT = 3'd1,
        ERR_UNDERFLOW     = 3'd2,
        ERR_OVERFLOW      = 3'd3
    } error_e;

    typedef enum logic [1:0] {
        FLOW_NONE  = 2'd0,
        FLOW_OVER  = 2'd1,
        FLOW_UNDER = 2'd2
    } flow_e;

    typedef enum logic [1:0] {
        SPC_NONE,
        SPC_X_ZERO,
        SPC_Y_ZERO,
        SPC_INVALID
    } special_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_CAPTURE,
        ST_ALIGN,
        ST_ADD,
        ST_NORMAL,
        ST_ROUND
    } state_e;

    // raw adder output, top mant bit is the carry
    typedef struct packed {
        logic              sign;
        logic [EXP_W-1:0]  exp;
        logic [MANT_W:0]   mant;
    } sum_t;

endpackage

// File: rtl/fadd_operand_if.sv
//====================
// aligned operand pair handed from the alignment stage
// to the significand adder
//====================
`timescale 1ns/1ps

interface fadd_operand_if;

    // operand with the larger magnitude
    logic                        big_sign;
    logic [fadd_pkg::MANT_W-1:0] big_mant;   // hidden bit, fraction, zero grs

    // operand with the smaller magnitude, shifted to the common exponent
    logic                        small_sign;
    logic [fadd_pkg::MANT_W-1:0] small_mant; // lowest bit carries sticky

    logic [fadd_pkg::EXP_W-1:0]  exp;        // common exponent of both

    // alignment side
    modport src (
        output big_sign,
        output big_mant,
        output small_sign,
        output small_mant,
        output exp
    );

    // adder side
    modport dst (
        input big_sign,
        input big_mant,
        input small_sign,
        input small_mant,
        input exp
    );

endinterface

// File: rtl/fadd_input_watch.sv
//====================
// change detector on x, y and round against a registered copy
//====================
`timescale 1ns/1ps

module fadd_input_watch (
    input  logic             clk,
    input  logic             rst,
    input  logic [31:0]      x,
    input  logic [31:0]      y,
    input  logic [1:0]       round,
    input  fadd_pkg::state_e state,
    output logic             change
);

    logic [31:0] x_q;
    logic [31:0] y_q;
    logic [1:0]  round_q;
    logic        differ;
    logic        accept;

    assign differ = (x != x_q) || (y != y_q) || (round != round_q);
    assign accept = (state == fadd_pkg::ST_IDLE) && differ && !change; // one pulse per change

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            x_q     <= '0;
            y_q     <= '0;
            round_q <= '0;
            change  <= 1'b0;
        end else begin
            change <= accept;
            if (accept) begin
                x_q     <= x;     // copy only moves when the change is taken
                y_q     <= y;
                round_q <= round;
            end
        end
    end

endmodule

// File: rtl/fadd_control.sv
//====================
// sequencing FSM of the adder
// special operands jump from capture straight to round
//====================
`timescale 1ns/1ps

module fadd_control (
    input  logic               clk,
    input  logic               rst,
    input  logic               change,
    input  fadd_pkg::special_e special,
    output fadd_pkg::state_e   state
);

    fadd_pkg::state_e state_nxt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= fadd_pkg::ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            fadd_pkg::ST_IDLE: begin
                if (change) begin
                    state_nxt = fadd_pkg::ST_CAPTURE;
                end
            end
            fadd_pkg::ST_CAPTURE: begin
                if (special != fadd_pkg::SPC_NONE) begin
                    state_nxt = fadd_pkg::ST_ROUND;   // zero or invalid operand
                end else begin
                    state_nxt = fadd_pkg::ST_ALIGN;
                end
            end
            fadd_pkg::ST_ALIGN: begin
                state_nxt = fadd_pkg::ST_ADD;
            end
            fadd_pkg::ST_ADD: begin
                state_nxt = fadd_pkg::ST_NORMAL;
            end
            fadd_pkg::ST_NORMAL: begin
                state_nxt = fadd_pkg::ST_ROUND;
            end
            fadd_pkg::ST_ROUND: begin
                state_nxt = fadd_pkg::ST_IDLE;
            end
            default: begin
                state_nxt = fadd_pkg::ST_IDLE;
            end
        endcase
    end

endmodule

// File: rtl/fadd_align.sv
//====================
// operand classification and exponent alignment
// shifted out bits of the smaller operand collapse into sticky
//====================
`timescale 1ns/1ps

module fadd_align (
    input  logic               clk,
    input  logic               rst,
    input  fadd_pkg::state_e   state,
    input  logic [31:0]        x,
    input  logic [31:0]        y,
    output fadd_pkg::special_e special,
    output logic [31:0]        pass,
    fadd_operand_if.src        ops
);

    localparam int SIG_W   = fadd_pkg::FRAC_W + 1;
    localparam int SHIFT_W = $clog2(fadd_pkg::MAX_SHIFT + 1);

    logic                       sx, sy;
    logic [fadd_pkg::EXP_W-1:0] ex, ey;
    logic [SIG_W-1:0]           mx, my;      // hidden bit restored

    logic                        x_inv, y_inv, x_zero, y_zero;
    logic                        x_big;
    logic [fadd_pkg::EXP_W-1:0]  exp_diff;
    logic [SHIFT_W-1:0]          shift;
    logic [fadd_pkg::MANT_W-1:0] small_ext, small_sh, lost_mask;

    // inf/nan exponent, or denormal
    assign x_inv  = (&x[30:23]) || (x[30:23] == '0 && x[22:0] != '0);
    assign y_inv  = (&y[30:23]) || (y[30:23] == '0 && y[22:0] != '0);
    assign x_zero = (x[30:0] == '0);
    assign y_zero = (y[30:0] == '0);

    assign x_big     = {ex, mx} >= {ey, my};
    assign exp_diff  = x_big ? (ex - ey) : (ey - ex);
    assign shift     = (exp_diff > fadd_pkg::MAX_SHIFT) ? SHIFT_W'(fadd_pkg::MAX_SHIFT)
                                                        : exp_diff[SHIFT_W-1:0];
    assign small_ext = {(x_big ? my : mx), {fadd_pkg::GRS_W{1'b0}}};
    assign small_sh  = small_ext >> shift;
    assign lost_mask = ~({fadd_pkg::MANT_W{1'b1}} << shift);

    // operands are sampled every idle cycle so the class is ready in capture
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            special <= fadd_pkg::SPC_NONE;
        end else if (state == fadd_pkg::ST_IDLE) begin
            if (x_inv || y_inv) begin
                special <= fadd_pkg::SPC_INVALID;
            end else if (x_zero) begin
                special <= fadd_pkg::SPC_X_ZERO;
            end else if (y_zero) begin
                special <= fadd_pkg::SPC_Y_ZERO;
            end else begin
                special <= fadd_pkg::SPC_NONE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == fadd_pkg::ST_IDLE) begin
            pass <= x_zero ? y : x;
            sx   <= x[31];
            sy   <= y[31];
            ex   <= x[30:23];
            ey   <= y[30:23];
            mx   <= {1'b1, x[22:0]};
            my   <= {1'b1, y[22:0]};
        end
        if (state == fadd_pkg::ST_ALIGN) begin
            ops.big_sign   <= x_big ? sx : sy;
            ops.big_mant   <= {(x_big ? mx : my), {fadd_pkg::GRS_W{1'b0}}};
            ops.small_sign <= x_big ? sy : sx;
            ops.small_mant <= {small_sh[fadd_pkg::MANT_W-1:1],
                               small_sh[0] | (|(small_ext & lost_mask))};
            ops.exp        <= x_big ? ex : ey;
        end
    end

endmodule

// File: rtl/fadd_mant_addsub.sv
//====================
// significand add or subtract on the aligned pair
// result keeps the carry bit for the normalizer
//====================
`timescale 1ns/1ps

module fadd_mant_addsub (
    input  logic             clk,
    input  logic             rst,
    input  fadd_pkg::state_e state,
    input  logic [1:0]       round,
    fadd_operand_if.dst      ops,
    output fadd_pkg::sum_t   sum
);

    logic                      eff_sub;
    logic [fadd_pkg::MANT_W:0] big_w;
    logic [fadd_pkg::MANT_W:0] small_w;
    logic [fadd_pkg::MANT_W:0] result;
    logic                      res_sign;

    assign eff_sub = ops.big_sign ^ ops.small_sign;
    assign big_w   = {1'b0, ops.big_mant};
    assign small_w = {1'b0, ops.small_mant};

    // big is never below small, so the difference stays positive
    assign result = eff_sub ? (big_w - small_w) : (big_w + small_w);

    always_comb begin
        res_sign = ops.big_sign;
        if (eff_sub && result == '0) begin
            // exact cancellation gives +0, or -0 when rounding down
            res_sign = (round == fadd_pkg::RND_NEG_INF);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sum <= '0;
        end else if (state == fadd_pkg::ST_ADD) begin
            sum.sign <= res_sign;
            sum.exp  <= ops.exp;
            sum.mant <= result;
        end
    end

endmodule

// File: rtl/fadd_norm_round.sv
//====================
// normalize, range check and round the raw sum
// drives the registered result word and status
//====================
`timescale 1ns/1ps

module fadd_norm_round (
    input  logic               clk,
    input  logic               rst,
    input  fadd_pkg::state_e   state,
    input  logic [1:0]         round,
    input  fadd_pkg::special_e special,
    input  logic [31:0]        pass,
    input  fadd_pkg::sum_t     sum,
    output logic [31:0]        z,
    output logic [2:0]         error,
    output logic [1:0]         overflow
);

    localparam int SIG_W = fadd_pkg::FRAC_W + 1;
    localparam int LZ_W  = $clog2(fadd_pkg::MANT_W + 1);
    localparam int EW_W  = fadd_pkg::EXP_W + 2;   // signed room for both ends

    logic                        n_sign, n_ovf, n_unf, n_zero;
    logic [fadd_pkg::EXP_W-1:0]  n_exp;
    logic [fadd_pkg::MANT_W-1:0] n_mant;

    logic                        carry;
    logic [LZ_W-1:0]             lz;
    logic signed [EW_W-1:0]      e_wide;
    logic [fadd_pkg::MANT_W-1:0] norm_mant;

    logic                        lsb, g, r, s, up;
    logic [SIG_W:0]              rounded;
    logic [fadd_pkg::EXP_W:0]    exp_r;
    logic [fadd_pkg::FRAC_W-1:0] frac_r;

    // leading zeros of the sum without its carry bit
    function automatic logic [LZ_W-1:0] lzc(input logic [fadd_pkg::MANT_W-1:0] v);
        logic [LZ_W-1:0] n;
        n = LZ_W'(fadd_pkg::MANT_W);
        for (int i = 0; i < fadd_pkg::MANT_W; i++) begin
            if (v[i]) begin
                n = LZ_W'(fadd_pkg::MANT_W - 1 - i);
            end
        end
        return n;
    endfunction

    assign carry = sum.mant[fadd_pkg::MANT_W];
    assign lz    = lzc(sum.mant[fadd_pkg::MANT_W-1:0]);

    always_comb begin
        if (carry) begin
            norm_mant = {sum.mant[fadd_pkg::MANT_W:2], sum.mant[1] | sum.mant[0]};
            e_wide    = $signed({2'b00, sum.exp}) + EW_W'(1);
        end else begin
            norm_mant = sum.mant[fadd_pkg::MANT_W-1:0] << lz;
            e_wide    = $signed({2'b00, sum.exp}) - $signed({{(EW_W-LZ_W){1'b0}}, lz});
        end
    end

    assign lsb = n_mant[fadd_pkg::GRS_W];
    assign g   = n_mant[2];
    assign r   = n_mant[1];
    assign s   = n_mant[0];

    always_comb begin
        case (round)
            fadd_pkg::RND_NEAREST_EVEN: up = g & (r | s | lsb);
            fadd_pkg::RND_POS_INF:      up = !n_sign & (g | r | s);
            fadd_pkg::RND_NEG_INF:      up = n_sign & (g | r | s);
            default:                    up = 1'b0;   // toward zero truncates
        endcase
    end

    assign rounded = {1'b0, n_mant[fadd_pkg::MANT_W-1 -: SIG_W]} + {{SIG_W{1'b0}}, up};
    assign exp_r   = {1'b0, n_exp} + {{fadd_pkg::EXP_W{1'b0}}, rounded[SIG_W]};
    assign frac_r  = rounded[fadd_pkg::FRAC_W-1:0];   // increment carry leaves all zeros

    always_ff @(posedge clk) begin
        if (state == fadd_pkg::ST_NORMAL) begin
            n_sign <= sum.sign;
            n_exp  <= e_wide[fadd_pkg::EXP_W-1:0];
            n_mant <= norm_mant;
            n_zero <= (sum.mant == '0);
            n_ovf  <= (e_wide > fadd_pkg::EXP_MAX);
            n_unf  <= (e_wide < 1) && (sum.mant != '0);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            z        <= '0;
            error    <= fadd_pkg::ERR_NONE;
            overflow <= fadd_pkg::FLOW_NONE;
        end else if (state == fadd_pkg::ST_ROUND) begin
            error    <= fadd_pkg::ERR_NONE;
            overflow <= fadd_pkg::FLOW_NONE;
            if (special == fadd_pkg::SPC_INVALID) begin
                z     <= '0;
                error <= fadd_pkg::ERR_INVALID_INPUT;
            end else if (special != fadd_pkg::SPC_NONE) begin
                z <= pass;                              // other operand was zero
            end else if (n_ovf || exp_r > fadd_pkg::EXP_MAX) begin
                z        <= {n_sign, {fadd_pkg::EXP_W{1'b1}}, {fadd_pkg::FRAC_W{1'b0}}};
                error    <= fadd_pkg::ERR_OVERFLOW;
                overflow <= fadd_pkg::FLOW_OVER;
            end else if (n_unf) begin
                z        <= {n_sign, 31'b0};
                error    <= fadd_pkg::ERR_UNDERFLOW;
                overflow <= fadd_pkg::FLOW_UNDER;
            end else if (n_zero) begin
                z <= {n_sign, 31'b0};                   // exact cancellation
            end else begin
                z <= {n_sign, exp_r[fadd_pkg::EXP_W-1:0], frac_r};
            end
        end
    end

endmodule

// File: rtl/fadd_top.sv
//====================
// sequential binary32 adder, new operation on any input change
// z, error and overflow update at the end of the round state
//====================
`timescale 1ns/1ps

module fadd_top (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] x,
    input  logic [31:0] y,
    input  logic [1:0]  round,
    output logic [31:0] z,
    output logic [2:0]  error,
    output logic [1:0]  overflow
);

    fadd_pkg::state_e   state;
    fadd_pkg::special_e special;
    fadd_pkg::sum_t     sum;
    logic               change;
    logic [31:0]        pass;    // operand returned when the other is zero

    fadd_operand_if ops ();

    fadd_input_watch i_fadd_input_watch (
        .clk    (clk),
        .rst    (rst),
        .x      (x),
        .y      (y),
        .round  (round),
        .state  (state),
        .change (change)
    );

    fadd_control i_fadd_control (
        .clk     (clk),
        .rst     (rst),
        .change  (change),
        .special (special),
        .state   (state)
    );

    fadd_align i_fadd_align (
        .clk     (clk),
        .rst     (rst),
        .state   (state),
        .x       (x),
        .y       (y),
        .special (special),
        .pass    (pass),
        .ops     (ops.src)
    );

    fadd_mant_addsub i_fadd_mant_addsub (
        .clk   (clk),
        .rst   (rst),
        .state (state),
        .round (round),
        .ops   (ops.dst),
        .sum   (sum)
    );

    fadd_norm_round i_fadd_norm_round (
        .clk      (clk),
        .rst      (rst),
        .state    (state),
        .round    (round),
        .special  (special),
        .pass     (pass),
        .sum      (sum),
        .z        (z),
        .error    (error),
        .overflow (overflow)
    );

endmodule

// File: test/fadd_tb.sv
//====================
// testbench of the binary32 adder, runs every line of test/fadd_vectors.txt
// through the DUT and compares z, error and overflow
//====================
`timescale 1ns/1ps

module fadd_tb;

    localparam string VEC_FILE     = "test/fadd_vectors.txt";
    localparam int    MIN_VECTORS  = 20;
    localparam int    SETTLE_EDGES = 9;   // longest operation needs 7

    logic        clk;
    logic        rst;
    logic [31:0] x;
    logic [31:0] y;
    logic [1:0]  round;
    logic [31:0] z;
    logic [2:0]  error;
    logic [1:0]  overflow;

    // one entry per vector line
    logic [31:0] vec_x[$];
    logic [31:0] vec_y[$];
    logic [1:0]  vec_round[$];
    logic [31:0] vec_z[$];
    logic [2:0]  vec_err[$];
    logic [1:0]  vec_flow[$];

    fadd_top i_fadd_top (
        .clk      (clk),
        .rst      (rst),
        .x        (x),
        .y        (y),
        .round    (round),
        .z        (z),
        .error    (error),
        .overflow (overflow)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;   // 100 ns period
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic compare_word(input string name, input logic [31:0] got,
                                input logic [31:0] want, input string where);
        assert (got === want) else begin
            abort_run($sformatf("** Error: %s = %h, expected %h (%s)",
                                name, got, want, where));
        end
    endtask

    task automatic load_vectors();
        int          fd;
        int          fields;
        int          line_no;
        string       line;
        logic [31:0] f [6];
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            abort_run({"could not open the vector file ", VEC_FILE});
        end
        line_no = 0;
        while ($fgets(line, fd) != 0) begin
            line_no++;
            if (line.len() == 0 || line.getc(0) == "#" || line.getc(0) == 8'h0a) begin
                continue;   // comment or blank line
            end
            fields = $sscanf(line, "%h %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4], f[5]);
            if (fields != 6) begin
                abort_run($sformatf("vector file line %0d holds %0d values instead of 6",
                                    line_no, fields));
            end
            vec_x.push_back(f[0]);
            vec_y.push_back(f[1]);
            vec_round.push_back(f[2][1:0]);
            vec_z.push_back(f[3]);
            vec_err.push_back(f[4][2:0]);
            vec_flow.push_back(f[5][1:0]);
        end
        $fclose(fd);
        if (vec_x.size() < MIN_VECTORS) begin
            abort_run($sformatf("vector file is too short, only %0d vectors were read",
                                vec_x.size()));
        end
    endtask

    task automatic run_vector(input int idx);
        string where;
        where = $sformatf("vector %0d", idx);
        @(posedge clk);
        x     <= vec_x[idx];
        y     <= vec_y[idx];
        round <= vec_round[idx];
        for (int n = 0; n < SETTLE_EDGES; n++) begin
            @(posedge clk);
        end
        @(negedge clk);   // away from the output update edge
        compare_word("z", z, vec_z[idx], where);
        compare_word("error", 32'(error), 32'(vec_err[idx]), where);
        compare_word("overflow", 32'(overflow), 32'(vec_flow[idx]), where);
    endtask

    initial begin
        rst   <= 1'b1;
        x     <= '0;
        y     <= '0;
        round <= '0;
        load_vectors();
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        compare_word("z", z, 32'h0, "after reset");
        compare_word("error", 32'(error), 32'(fadd_pkg::ERR_NONE), "after reset");
        compare_word("overflow", 32'(overflow), 32'(fadd_pkg::FLOW_NONE), "after reset");
        for (int i = 0; i < vec_x.size(); i++) begin
            run_vector(i);
        end
        $display("%0d vectors checked", vec_x.size());
        $display("All tests passed!");
        $finish;
    end

endmodule

// File: test/fadd_vectors.txt
# x y round z error overflow, all hex, one operation per line
# round 0 toward zero, 1 nearest even, 2 toward +inf, 3 toward -inf
3F800000 3F000000 1 3FC00000 0 0
3FC00000 3FC00000 0 40400000 0 0
3F800001 3F800000 0 40000000 0 0
3F800001 3F800000 1 40000000 0 0
3F800001 3F800000 2 40000001 0 0
3F800001 3F800000 3 40000000 0 0
3F800003 3F800000 1 40000002 0 0
BF800000 BF800001 2 C0000000 0 0
BF800000 BF800001 3 C0000001 0 0
3F800000 33C00000 1 3F800001 0 0
3F800001 BF800000 1 34000000 0 0
3F800000 BF7FFFFF 0 33800000 0 0
40490FDB C0490FDB 0 00000000 0 0
40490FDB C0490FDB 3 80000000 0 0
3F800000 2B800000 0 3F800000 0 0
3F800000 2B800000 1 3F800000 0 0
3F800000 2B800000 2 3F800001 0 0
3F800000 2B800000 3 3F800000 0 0
3F800000 AB800000 0 3F7FFFFF 0 0
3F800000 AB800000 1 3F800000 0 0
3F800000 AB800000 3 3F7FFFFF 0 0
00000000 40490FDB 0 40490FDB 0 0
00000000 40490FDB 2 40490FDB 0 0
C0000000 80000000 1 C0000000 0 0
7F800000 3F800000 1 00000000 1 0
3F800000 7FC00000 1 00000000 1 0
00000001 3F800000 1 00000000 1 0
7F7FFFFF 7F7FFFFF 1 7F800000 3 1
FF7FFFFF FF7FFFFF 1 FF800000 3 1
7F7FFFFF 73000000 1 7F800000 3 1
7F7FFFFF 73000000 0 7F7FFFFF 0 0
01000001 81000000 1 00000000 2 2
81000001 01000000 1 80000000 2 2

// File: src.f
rtl/fadd_pkg.sv
rtl/fadd_operand_if.sv
rtl/fadd_input_watch.sv
rtl/fadd_control.sv
rtl/fadd_align.sv
rtl/fadd_mant_addsub.sv
rtl/fadd_norm_round.sv
rtl/fadd_top.sv
test/fadd_tb.sv

// File: Makefile
# Verilator build and run of the binary32 adder testbench
# every variable below can be set on the make command line

VERILATOR ?= verilator
TOP       ?= fadd_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All tests passed!
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-$(SIM_BIN) | tee $(LOG)
	@if grep -qF "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
